// File: common/eth_frame_pkg.sv
// Ethernet frame format package
// Byte and CRC types, framing constants and the CRC-32 byte step shared by
// the transmit and receive paths
package eth_frame_pkg;

    // One byte on the GMII side or the stream side
    typedef logic [7:0] octet_t;

    // Running CRC-32 register, reflected form
    typedef logic [31:0] crc_t;

    localparam octet_t preamble_byte = 8'h55;
    localparam octet_t sfd_byte      = 8'hD5;

    // Sent with gmii_tx_er to poison a frame on the wire
    localparam octet_t error_byte = 8'hFE;

    localparam int preamble_len = 7;
    localparam int fcs_len      = 4;

    // Minimum frame counts the FCS, so payload pads to 60 bytes
    localparam int min_frame_len   = 64;
    localparam int min_payload_len = min_frame_len - fcs_len;

    // Short frames are always padded in this MAC
    localparam bit enable_padding = 1'b1;

    // Register value left after a good frame with its FCS run through
    localparam crc_t crc_residue = 32'hDEBB20E3;

    localparam crc_t crc_poly = 32'hEDB88320;

    // One byte step of the reflected CRC-32, LSB of the byte first
    function automatic crc_t crc32_update(crc_t crc, octet_t data);
        crc_t c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: common/eth_mac_pkg.sv
// Ethernet MAC control package
// Link speed encoding, inter-frame gap floor and the state encodings of the
// transmit and receive FSMs
package eth_mac_pkg;

    // Matches the reference speed code, 1000 Mb/s after reset
    typedef enum logic [1:0] {
        speed_10   = 2'd0,
        speed_100  = 2'd1,
        speed_1000 = 2'd2
    } speed_t;

    // IEEE gap floor in byte times
    localparam int min_ifg = 12;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_payload,
        tx_pad,
        tx_fcs,
        tx_gap
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_payload,
        rx_drop
    } rx_state_t;

endpackage

// File: eth_mac/eth_mac_tx.sv
// Ethernet MAC transmit framer
// Turns a valid/ready byte stream into a GMII frame with preamble, SFD,
// zero padding, CRC-32 FCS and a programmable inter-frame gap
module eth_mac_tx (
    input  logic                  gtx_clk,
    input  logic                  gtx_rst,
    input  eth_frame_pkg::octet_t tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    input  logic                  tx_last,
    input  logic                  tx_user,
    output eth_frame_pkg::octet_t gmii_txd,
    output logic                  gmii_tx_en,
    output logic                  gmii_tx_er,
    output logic                  tx_error_underflow,
    input  eth_frame_pkg::octet_t ifg_delay
);
    import eth_frame_pkg::*;
    import eth_mac_pkg::*;

    tx_state_t  state;
    crc_t       crc;
    // Preamble byte count, reused for the FCS bytes
    logic [2:0] step_cnt;
    // Payload bytes sent, saturates well above the pad limit
    logic [5:0] byte_cnt;
    octet_t     gap_cnt;
    octet_t     gap_load;
    // Underflow seen, swallow the stream up to tx_last
    logic       drain;
    // tx_user on the last byte, error byte replaces the FCS
    logic       abort;

    // Gap counter reload, never below the IEEE floor
    assign gap_load = (ifg_delay < octet_t'(min_ifg)) ? octet_t'(min_ifg - 1)
                                                       : ifg_delay - 8'd1;

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state              <= tx_idle;
            tx_ready           <= 1'b0;
            gmii_tx_en         <= 1'b0;
            gmii_tx_er         <= 1'b0;
            tx_error_underflow <= 1'b0;
            step_cnt           <= '0;
            byte_cnt           <= '0;
            gap_cnt            <= '0;
            drain              <= 1'b0;
            abort              <= 1'b0;
        end else begin
            tx_error_underflow <= 1'b0;

            case (state)
                tx_idle: begin
                    if (tx_valid) begin
                        // First preamble byte goes out right away
                        gmii_txd   <= preamble_byte;
                        gmii_tx_en <= 1'b1;
                        gmii_tx_er <= 1'b0;
                        step_cnt   <= 3'd1;
                        byte_cnt   <= '0;
                        crc        <= '1;
                        state      <= tx_preamble;
                    end
                end

                tx_preamble: begin
                    if (step_cnt == 3'(preamble_len)) begin
                        // SFD on the wire while the first byte is taken
                        gmii_txd <= sfd_byte;
                        tx_ready <= 1'b1;
                        state    <= tx_payload;
                    end else begin
                        gmii_txd <= preamble_byte;
                        step_cnt <= step_cnt + 3'd1;
                    end
                end

                tx_payload: begin
                    if (drain) begin
                        // Line already quiet, just eat the rest of the frame
                        gmii_tx_en <= 1'b0;
                        gmii_tx_er <= 1'b0;
                        if (tx_valid && tx_last) begin
                            tx_ready <= 1'b0;
                            drain    <= 1'b0;
                            gap_cnt  <= gap_load;
                            state    <= tx_gap;
                        end
                    end else if (tx_valid) begin
                        gmii_txd <= tx_data;
                        crc      <= crc32_update(crc, tx_data);
                        if (~&byte_cnt) begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                        if (tx_last) begin
                            tx_ready <= 1'b0;
                            step_cnt <= '0;
                            if (tx_user) begin
                                abort <= 1'b1;
                                state <= tx_fcs;
                            end else if (enable_padding &&
                                         byte_cnt < 6'(min_payload_len - 1)) begin
                                state <= tx_pad;
                            end else begin
                                state <= tx_fcs;
                            end
                        end
                    end else begin
                        // Stream ran dry mid-frame
                        gmii_txd           <= error_byte;
                        gmii_tx_er         <= 1'b1;
                        tx_error_underflow <= 1'b1;
                        drain              <= 1'b1;
                    end
                end

                tx_pad: begin
                    gmii_txd <= 8'h00;
                    crc      <= crc32_update(crc, 8'h00);
                    byte_cnt <= byte_cnt + 6'd1;
                    // This byte is number byte_cnt + 1
                    if (byte_cnt == 6'(min_payload_len - 1)) begin
                        state <= tx_fcs;
                    end
                end

                tx_fcs: begin
                    if (abort) begin
                        gmii_txd   <= error_byte;
                        gmii_tx_er <= 1'b1;
                        abort      <= 1'b0;
                        gap_cnt    <= gap_load;
                        state      <= tx_gap;
                    end else begin
                        // Inverted CRC, low byte first
                        gmii_txd <= ~crc[7:0];
                        crc      <= {8'h00, crc[31:8]};
                        step_cnt <= step_cnt + 3'd1;
                        if (step_cnt == 3'(fcs_len - 1)) begin
                            gap_cnt <= gap_load;
                            state   <= tx_gap;
                        end
                    end
                end

                tx_gap: begin
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    if (gap_cnt == '0) begin
                        state <= tx_idle;
                    end else begin
                        gap_cnt <= gap_cnt - 8'd1;
                    end
                end

                default: begin
                    state <= tx_idle;
                end
            endcase
        end
    end

    // Error code only shows up inside an active frame
    a_tx_er_in_frame: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        $rose(gmii_tx_er) |-> gmii_tx_en);

    // Stream is only accepted while the FSM sits in payload
    a_ready_in_payload: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        (state != tx_payload) |-> !tx_ready);

endmodule

// File: eth_mac/eth_mac_rx.sv
// Ethernet MAC receive deframer
// Strips preamble and SFD from GMII, holds back the FCS, checks the CRC-32
// residue and flags bad frames on the last output byte
module eth_mac_rx (
    input  logic                  gtx_clk,
    input  logic                  gtx_rst,
    input  eth_frame_pkg::octet_t gmii_rxd,
    input  logic                  gmii_rx_dv,
    input  logic                  gmii_rx_er,
    output eth_frame_pkg::octet_t rx_data,
    output logic                  rx_valid,
    output logic                  rx_last,
    output logic                  rx_user,
    output logic                  rx_error_bad_frame,
    output logic                  rx_error_bad_fcs
);
    import eth_frame_pkg::*;
    import eth_mac_pkg::*;

    rx_state_t              state;
    crc_t                   crc;
    // FCS holdback, newest byte in slot 0
    octet_t [fcs_len-1:0]   hold;
    // Byte past the holdback, waits to learn if it ends the frame
    octet_t                 cand;
    // Bytes in holdback plus candidate, saturates when full
    logic [2:0]             fill;
    // rx_er seen somewhere in the frame
    logic                   bad;
    logic                   fcs_ok;

    assign fcs_ok = (crc == crc_residue);

    // Bytes leave five clocks after they are sampled from the PHY
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state              <= rx_idle;
            fill               <= '0;
            bad                <= 1'b0;
            rx_valid           <= 1'b0;
            rx_last            <= 1'b0;
            rx_user            <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;
        end else begin
            rx_valid           <= 1'b0;
            rx_last            <= 1'b0;
            rx_user            <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs   <= 1'b0;

            case (state)
                rx_idle: begin
                    if (gmii_rx_dv) begin
                        if (gmii_rxd == sfd_byte) begin
                            crc   <= '1;
                            fill  <= '0;
                            bad   <= gmii_rx_er;
                            state <= rx_payload;
                        end else if (gmii_rxd != preamble_byte) begin
                            // No SFD after the preamble
                            state <= rx_drop;
                        end
                    end
                end

                rx_payload: begin
                    if (gmii_rx_dv) begin
                        hold <= {hold[fcs_len-2:0], gmii_rxd};
                        cand <= hold[fcs_len-1];
                        crc  <= crc32_update(crc, gmii_rxd);
                        bad  <= bad | gmii_rx_er;
                        if (fill == 3'(fcs_len + 1)) begin
                            rx_data  <= cand;
                            rx_valid <= 1'b1;
                        end else begin
                            fill <= fill + 3'd1;
                        end
                    end else begin
                        state <= rx_idle;
                        // Candidate is the final payload byte, holdback is the FCS
                        // Runts that never filled the holdback vanish here
                        if (fill == 3'(fcs_len + 1)) begin
                            rx_data            <= cand;
                            rx_valid           <= 1'b1;
                            rx_last            <= 1'b1;
                            rx_user            <= bad | ~fcs_ok;
                            rx_error_bad_frame <= bad;
                            rx_error_bad_fcs   <= ~bad & ~fcs_ok;
                        end
                    end
                end

                rx_drop: begin
                    if (!gmii_rx_dv) begin
                        state <= rx_idle;
                    end
                end

                default: begin
                    state <= rx_idle;
                end
            endcase
        end
    end

    // Frame end is always carried by a real output byte
    a_last_with_valid: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        rx_last |-> rx_valid);

endmodule

// File: source/eth_speed_detect.sv
// PHY speed detector
// Counts prescaled edges of the PHY receive clock against gtx_clk and
// reports the link rate as 10, 100 or 1000 Mb/s
module eth_speed_detect (
    input  logic                gtx_clk,
    input  logic                gtx_rst,
    input  logic                gmii_rx_clk,
    output eth_mac_pkg::speed_t speed
);
    import eth_mac_pkg::*;

    // Free running in the PHY clock domain
    logic [2:0] rx_prescale = '0;
    // Top prescaler bit brought into gtx_clk
    logic [2:0] prescale_sync = '0;
    logic       prescale_edge;
    logic [6:0] ref_cnt;
    logic [1:0] edge_cnt;

    always_ff @(posedge gmii_rx_clk) begin
        rx_prescale <= rx_prescale + 3'd1;
    end

    always_ff @(posedge gtx_clk) begin
        prescale_sync <= {prescale_sync[1:0], rx_prescale[2]};
    end

    // Either toggle of the prescaler top bit counts, once per 4 rx clocks
    assign prescale_edge = prescale_sync[2] ^ prescale_sync[1];

    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            ref_cnt  <= '0;
            edge_cnt <= '0;
            speed    <= speed_1000;
        end else begin
            ref_cnt <= ref_cnt + 7'd1;
            if (prescale_edge) begin
                edge_cnt <= edge_cnt + 2'd1;
            end

            // Reference ran out first, slow clock
            if (&ref_cnt) begin
                ref_cnt  <= '0;
                edge_cnt <= '0;
                speed    <= speed_10;
            end

            // Edge counter full, reference count tells 100 from 1000
            if (&edge_cnt) begin
                ref_cnt  <= '0;
                edge_cnt <= '0;
                if (ref_cnt[6:5] != 2'b00) begin
                    speed <= speed_100;
                end else begin
                    speed <= speed_1000;
                end
            end
        end
    end

endmodule

// File: source/eth_mac_1g_gmii.sv
// Gigabit Ethernet MAC with GMII byte interface
// Joins the transmit framer, receive deframer and PHY speed detector,
// all on gtx_clk
module eth_mac_1g_gmii (
    input  logic                  gtx_clk,
    input  logic                  gtx_rst,

    // Transmit stream
    input  eth_frame_pkg::octet_t tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    input  logic                  tx_last,
    input  logic                  tx_user,

    // Receive stream, cannot be stalled
    output eth_frame_pkg::octet_t rx_data,
    output logic                  rx_valid,
    output logic                  rx_last,
    output logic                  rx_user,

    // GMII
    input  logic                  gmii_rx_clk,
    input  eth_frame_pkg::octet_t gmii_rxd,
    input  logic                  gmii_rx_dv,
    input  logic                  gmii_rx_er,
    output eth_frame_pkg::octet_t gmii_txd,
    output logic                  gmii_tx_en,
    output logic                  gmii_tx_er,

    // Status pulses and link rate
    output logic                  tx_error_underflow,
    output logic                  rx_error_bad_frame,
    output logic                  rx_error_bad_fcs,
    output eth_mac_pkg::speed_t   speed,

    // Gap length in byte times
    input  eth_frame_pkg::octet_t ifg_delay
);

    eth_mac_tx u_tx (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .tx_last            (tx_last),
        .tx_user            (tx_user),
        .gmii_txd           (gmii_txd),
        .gmii_tx_en         (gmii_tx_en),
        .gmii_tx_er         (gmii_tx_er),
        .tx_error_underflow (tx_error_underflow),
        .ifg_delay          (ifg_delay)
    );

    eth_mac_rx u_rx (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .rx_last            (rx_last),
        .rx_user            (rx_user),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

    // Only the detector looks at the PHY receive clock
    eth_speed_detect u_speed (
        .gtx_clk     (gtx_clk),
        .gtx_rst     (gtx_rst),
        .gmii_rx_clk (gmii_rx_clk),
        .speed       (speed)
    );

endmodule

// File: sim/tb_eth_mac_1g.sv
// Loopback testbench for the gigabit Ethernet MAC
// Frames from a table go out on GMII, come back into the receiver and are
// checked against a local CRC-32 model, followed by the speed detector sweep
module tb_eth_mac_1g;
    timeunit 1ns;
    timeprecision 1ps;

    // One frame per row
    typedef struct packed {
        int         len;
        logic       flip;
        logic       force_er;
        logic       abort;
        logic       underflow;
        logic [7:0] ifg;
        logic       exp_user;
    } frame_row_t;

    localparam int         num_rows   = 8;
    // Wire byte hit by injection, payload byte 12 after preamble and SFD
    localparam int         inject_idx = 20;
    localparam logic [7:0] flip_mask  = 8'h10;
    // Payload byte after which the stream runs dry
    localparam int         stall_idx  = 20;
    // GMII error propagation code
    localparam logic [7:0] err_code   = 8'hFE;

    logic       gtx_clk;
    logic       gtx_rst;
    logic       gmii_rx_clk;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       tx_last;
    logic       tx_user;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_last;
    logic       rx_user;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic       tx_error_underflow;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic [1:0] speed;
    logic [7:0] ifg_delay;

    frame_row_t  rows [num_rows];
    logic [7:0]  payload[$];
    // Expected wire bytes with gmii_tx_er in bit 8
    logic [8:0]  exp_wire[$];
    logic [7:0]  exp_rx[$];
    logic [31:0] lcg_state;
    int          rx_half;
    logic        flip_en;
    logic        er_en;
    int          gap_need;
    int          wire_cnt;
    int          wire_len;
    int          idle_run;
    int          gap_req;
    int          frames_seen;
    logic        en_prev;
    int          rx_pos;
    int          rx_frames;
    logic        last_user;
    int          underflow_cnt;
    int          bad_fcs_cnt;
    int          bad_frame_cnt;
    int          main_errors;
    int          wire_errors;
    int          rx_errors;

    always #20 gtx_clk = ~gtx_clk;

    always begin
        #(rx_half);
        gmii_rx_clk = ~gmii_rx_clk;
    end

    // PHY loopback with optional corruption of one wire byte
    assign gmii_rxd   = gmii_txd ^ ((flip_en && wire_cnt == inject_idx) ? flip_mask : 8'h00);
    assign gmii_rx_dv = gmii_tx_en;
    assign gmii_rx_er = gmii_tx_er | (er_en && wire_cnt == inject_idx);

    eth_mac_1g_gmii UUT (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .tx_last            (tx_last),
        .tx_user            (tx_user),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .rx_last            (rx_last),
        .rx_user            (rx_user),
        .gmii_rx_clk        (gmii_rx_clk),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .gmii_txd           (gmii_txd),
        .gmii_tx_en         (gmii_tx_en),
        .gmii_tx_er         (gmii_tx_er),
        .tx_error_underflow (tx_error_underflow),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs),
        .speed              (speed),
        .ifg_delay          (ifg_delay)
    );

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] exp, inout int err_cnt);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // Bit serial CRC-32, feedback taken per data bit
    function automatic logic [31:0] crc_model(logic [31:0] c, logic [7:0] b);
        logic fb;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB88320;
            end
        end
        return c;
    endfunction

    // Wire image of the frame, then what the receiver should hand out
    task automatic build_expect(input frame_row_t row);
        logic [31:0] crc;
        logic [7:0]  b;
        int          stop;
        int          sent;
        exp_wire.delete();
        exp_rx.delete();
        for (int i = 0; i < 7; i++) begin
            exp_wire.push_back({1'b0, 8'h55});
        end
        exp_wire.push_back({1'b0, 8'hD5});
        crc  = 32'hFFFF_FFFF;
        stop = row.underflow ? stall_idx : row.len;
        for (sent = 0; sent < stop; sent++) begin
            exp_wire.push_back({1'b0, payload[sent]});
            crc = crc_model(crc, payload[sent]);
        end
        if (row.underflow || row.abort) begin
            exp_wire.push_back({1'b1, err_code});
        end else begin
            // Zero pad up to 60 bytes, FCS low byte first
            for (; sent < 60; sent++) begin
                exp_wire.push_back(9'h000);
                crc = crc_model(crc, 8'h00);
            end
            crc = ~crc;
            for (int i = 0; i < 4; i++) begin
                exp_wire.push_back({1'b0, crc[8*i +: 8]});
            end
        end
        // Receiver drops preamble, SFD and the last four wire bytes
        for (int k = 8; k < exp_wire.size() - 4; k++) begin
            b = exp_wire[k][7:0];
            if (row.flip && k == inject_idx) begin
                b = b ^ flip_mask;
            end
            exp_rx.push_back(b);
        end
    endtask

    task automatic drive_byte(input int idx, input int len, input logic user);
        tx_valid = 1'b1;
        tx_data  = payload[idx];
        tx_last  = (idx == len - 1);
        tx_user  = user && (idx == len - 1);
    endtask

    // Ready is sampled at the falling edge, the byte moves on the next rising edge
    task automatic send_frame(input int len, input int stall_at, input logic user);
        int   idx;
        int   waited;
        logic taken;
        logic stalled;
        idx     = 0;
        waited  = 0;
        stalled = 1'b0;
        @(posedge gtx_clk);
        #2;
        drive_byte(idx, len, user);
        while (idx < len && waited < 200) begin
            @(negedge gtx_clk);
            taken = tx_valid && tx_ready;
            @(posedge gtx_clk);
            #2;
            if (taken) begin
                idx++;
                waited = 0;
            end else begin
                waited++;
            end
            if (idx == len) begin
                tx_valid = 1'b0;
                tx_last  = 1'b0;
                tx_user  = 1'b0;
            end else if (idx == stall_at && !stalled) begin
                // One idle cycle mid-payload
                tx_valid = 1'b0;
                stalled  = 1'b1;
            end else begin
                drive_byte(idx, len, user);
            end
        end
        if (idx < len) begin
            $display("Timeout at %0t: transmitter never took payload byte %0d", $time, idx);
            main_errors++;
            tx_valid = 1'b0;
        end
    endtask

    task automatic wait_rx_frames(input int target);
        int cycles;
        cycles = 0;
        while (rx_frames < target && cycles < 1000) begin
            @(negedge gtx_clk);
            cycles++;
        end
        if (rx_frames < target) begin
            $display("Timeout at %0t: received frame %0d never ended", $time, target);
            main_errors++;
        end
    endtask

    always @(posedge gtx_clk) begin
        wire_cnt <= gmii_tx_en ? wire_cnt + 1 : 0;
    end

    // Wire bytes and inter-frame gap
    always @(negedge gtx_clk) begin
        if (gmii_tx_en) begin
            if (idle_run > 0 && frames_seen > 0) begin
                compare($sformatf("gap of %0d cycles reaches %0d", idle_run, gap_req),
                        32'(idle_run >= gap_req), 32'd1, wire_errors);
            end
            idle_run = 0;
            if (wire_cnt < exp_wire.size()) begin
                compare($sformatf("wire byte %0d", wire_cnt), {23'd0, gmii_tx_er, gmii_txd},
                        32'(exp_wire[wire_cnt]), wire_errors);
            end
            wire_len = wire_cnt + 1;
        end else begin
            if (en_prev) begin
                frames_seen++;
                gap_req = gap_need;
            end
            idle_run++;
        end
        en_prev = gmii_tx_en;
    end

    // Receive stream and status pulses, frame count bumped last
    always @(negedge gtx_clk) begin
        if (tx_error_underflow) underflow_cnt++;
        if (rx_error_bad_fcs) bad_fcs_cnt++;
        if (rx_error_bad_frame) bad_frame_cnt++;
        if (rx_valid) begin
            if (rx_pos < exp_rx.size()) begin
                compare($sformatf("rx byte %0d", rx_pos), 32'(rx_data), 32'(exp_rx[rx_pos]),
                        rx_errors);
            end
            rx_pos++;
            if (rx_last) begin
                compare("rx frame length", 32'(rx_pos), 32'(exp_rx.size()), rx_errors);
                last_user = rx_user;
                rx_pos    = 0;
                rx_frames++;
            end
        end
    end

    initial begin
        int         uf0;
        int         fcs0;
        int         frm0;
        int         cycles;
        int         speed_half [3];
        logic [1:0] speed_exp [3];
        frame_row_t row;

        gtx_clk       = 1'b0;
        gmii_rx_clk   = 1'b0;
        gtx_rst       = 1'b1;
        tx_data       = 8'h00;
        tx_valid      = 1'b0;
        tx_last       = 1'b0;
        tx_user       = 1'b0;
        ifg_delay     = 8'd12;
        rx_half       = 20;
        flip_en       = 1'b0;
        er_en         = 1'b0;
        lcg_state     = 32'h273b_2e33;
        gap_need      = 12;
        gap_req       = 12;
        wire_cnt      = 0;
        wire_len      = 0;
        idle_run      = 0;
        frames_seen   = 0;
        en_prev       = 1'b0;
        rx_pos        = 0;
        rx_frames     = 0;
        last_user     = 1'b0;
        underflow_cnt = 0;
        bad_fcs_cnt   = 0;
        bad_frame_cnt = 0;
        main_errors   = 0;
        wire_errors   = 0;
        rx_errors     = 0;

        // len, flip, rx_er, abort, underflow, ifg_delay, rx_user
        rows[0] = '{46, 1'b0, 1'b0, 1'b0, 1'b0, 8'd12, 1'b0};
        rows[1] = '{75, 1'b0, 1'b0, 1'b0, 1'b0, 8'd20, 1'b0};
        rows[2] = '{1,  1'b0, 1'b0, 1'b0, 1'b0, 8'd5,  1'b0};
        rows[3] = '{64, 1'b1, 1'b0, 1'b0, 1'b0, 8'd12, 1'b1};
        rows[4] = '{50, 1'b0, 1'b1, 1'b0, 1'b0, 8'd12, 1'b1};
        rows[5] = '{40, 1'b0, 1'b0, 1'b0, 1'b1, 8'd16, 1'b1};
        rows[6] = '{30, 1'b0, 1'b0, 1'b1, 1'b0, 8'd12, 1'b1};
        rows[7] = '{60, 1'b0, 1'b0, 1'b0, 1'b0, 8'd30, 1'b0};

        speed_half[0] = 200;
        speed_exp[0]  = 2'd1;
        speed_half[1] = 2000;
        speed_exp[1]  = 2'd0;
        speed_half[2] = 20;
        speed_exp[2]  = 2'd2;

        repeat (5) @(posedge gtx_clk);
        #2;
        gtx_rst = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            row = rows[r];
            @(posedge gtx_clk);
            #2;
            ifg_delay = row.ifg;
            gap_need  = (row.ifg < 8'd12) ? 12 : int'(row.ifg);
            flip_en   = row.flip;
            er_en     = row.force_er;
            payload.delete();
            for (int i = 0; i < row.len; i++) begin
                payload.push_back(next_random());
            end
            build_expect(row);
            uf0  = underflow_cnt;
            fcs0 = bad_fcs_cnt;
            frm0 = bad_frame_cnt;
            send_frame(row.len, row.underflow ? stall_idx : -1, row.abort);
            wait_rx_frames(r + 1);
            compare($sformatf("row %0d wire length", r), 32'(wire_len), 32'(exp_wire.size()),
                    main_errors);
            compare($sformatf("row %0d rx_user", r), 32'(last_user), 32'(row.exp_user),
                    main_errors);
            compare($sformatf("row %0d underflow pulses", r), 32'(underflow_cnt - uf0),
                    32'(row.underflow), main_errors);
            compare($sformatf("row %0d bad frame pulses", r), 32'(bad_frame_cnt - frm0),
                    32'(row.force_er | row.underflow | row.abort), main_errors);
            compare($sformatf("row %0d bad FCS pulses", r), 32'(bad_fcs_cnt - fcs0),
                    32'(row.flip), main_errors);
        end

        // Speed sweep, each rate must settle and then hold
        for (int s = 0; s < 3; s++) begin
            rx_half = speed_half[s];
            cycles  = 0;
            while (speed != speed_exp[s] && cycles < 2000) begin
                @(negedge gtx_clk);
                cycles++;
            end
            if (speed != speed_exp[s]) begin
                $display("Timeout at %0t: speed did not settle for rx half period %0d ns",
                         $time, speed_half[s]);
                main_errors++;
            end else begin
                repeat (200) @(negedge gtx_clk);
                compare($sformatf("speed held at half period %0d", speed_half[s]),
                        32'(speed), 32'(speed_exp[s]), main_errors);
            end
        end

        $display("Errors: main %0d, wire %0d, rx %0d", main_errors, wire_errors, rx_errors);
        if (main_errors + wire_errors + rx_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: eth_mac_1g.f
common/eth_frame_pkg.sv
common/eth_mac_pkg.sv
eth_mac/eth_mac_tx.sv
eth_mac/eth_mac_rx.sv
source/eth_speed_detect.sv
source/eth_mac_1g_gmii.sv
sim/tb_eth_mac_1g.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_eth_mac_1g -f eth_mac_1g.f
	@out="$$(./obj_dir/Vtb_eth_mac_1g)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
